// ==== flist.f ====
scratchpad_pkg.sv
mem_array.sv
load_ports.sv
store_tag_router.sv
store_pair_queue.sv
store_unit.sv
error_reporter.sv
scratchpad_memory.sv
scratchpad_checker.sv
tb_scratchpad_memory.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scratchpad_memory
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_scratchpad_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_scratchpad_memory;

  import scratchpad_pkg::*;

  localparam int MAX_STEPS = 128;

  // Step kinds
  localparam int K_IDLE   = 0;
  localparam int K_LOAD   = 1;
  localparam int K_DUAL   = 2;
  localparam int K_ADDR   = 3;
  localparam int K_DATA   = 4;
  localparam int K_STORE  = 5;
  localparam int K_XSTORE = 6;
  localparam int K_RESET  = 7;

  // Bits 0 to 2 of low pull down ld_resp_ready, ld_done_ready and st_done_ready
  typedef struct {
    int                    kind;
    int                    port;
    logic [TAG_WIDTH-1:0]  tag;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [2:0]            low;
    logic                  exp_rdy;
    int                    exp_st_done;
    logic [15:0]           exp_err;
  } step_t;

  logic                           clk;
  logic                           rst_n;
  logic [LD_COUNT-1:0]            ld_req_valid;
  logic [LD_COUNT-1:0]            ld_req_ready;
  payload_u [LD_COUNT-1:0]        ld_req;
  logic [LD_COUNT-1:0]            ld_resp_valid;
  logic [LD_COUNT-1:0]            ld_resp_ready;
  payload_u [LD_COUNT-1:0]        ld_resp;
  logic                           ld_done_valid;
  logic                           ld_done_ready;
  payload_u                       ld_done;
  logic [ST_COUNT-1:0]            st_addr_valid;
  logic [ST_COUNT-1:0]            st_addr_ready;
  payload_u [ST_COUNT-1:0]        st_addr;
  logic [ST_COUNT-1:0]            st_data_valid;
  logic [ST_COUNT-1:0]            st_data_ready;
  payload_u [ST_COUNT-1:0]        st_data;
  logic                           st_done_valid;
  logic                           st_done_ready;
  payload_u                       st_done;
  logic                           error_valid;
  logic [15:0]                    error_code;

  step_t                 steps [MAX_STEPS];
  int                    n_steps = 0;
  logic [15:0]           build_err = 16'h0000;
  logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];
  logic [ADDR_WIDTH-1:0] addr_q [ST_COUNT][$];
  logic [DATA_WIDTH-1:0] data_q [ST_COUNT][$];
  int                    mismatch_count = 0;
  int                    other_count = 0;
  int                    cycle_count = 0;

  scratchpad_memory #(
    .LSQ_DEPTH        (4),
    .DEADLOCK_TIMEOUT (16)
  ) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .ld_req_valid  (ld_req_valid),
    .ld_req_ready  (ld_req_ready),
    .ld_req        (ld_req),
    .ld_resp_valid (ld_resp_valid),
    .ld_resp_ready (ld_resp_ready),
    .ld_resp       (ld_resp),
    .ld_done_valid (ld_done_valid),
    .ld_done_ready (ld_done_ready),
    .ld_done       (ld_done),
    .st_addr_valid (st_addr_valid),
    .st_addr_ready (st_addr_ready),
    .st_addr       (st_addr),
    .st_data_valid (st_data_valid),
    .st_data_ready (st_data_ready),
    .st_data       (st_data),
    .st_done_valid (st_done_valid),
    .st_done_ready (st_done_ready),
    .st_done       (st_done),
    .error_valid   (error_valid),
    .error_code    (error_code)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Table construction

  task automatic add_step(input int kind, input int port, input logic [TAG_WIDTH-1:0] tag,
                          input logic [ADDR_WIDTH-1:0] addr, input logic [2:0] low,
                          input logic exp_rdy, input int exp_st_done);
    steps[n_steps].kind        = kind;
    steps[n_steps].port        = port;
    steps[n_steps].tag         = tag;
    steps[n_steps].addr        = addr;
    steps[n_steps].data        = $urandom();
    steps[n_steps].low         = low;
    steps[n_steps].exp_rdy     = exp_rdy;
    steps[n_steps].exp_st_done = exp_st_done;
    steps[n_steps].exp_err     = build_err;
    n_steps++;
  endtask

  task automatic add_idle(input int count, input int exp_st_done);
    for (int i = 0; i < count; i++) begin
      add_step(K_IDLE, 0, '0, '0, 3'b000, 1'b0, exp_st_done);
    end
  endtask

  task automatic build_table();
    // Store then load, plus load back-pressure
    add_step(K_STORE, 0, 0, 6'd5, 3'b000, 1'b1, -1);
    add_idle(1, 0);
    add_step(K_LOAD, 0, 1, 6'd5, 3'b000, 1'b1, -1);
    add_step(K_LOAD, 1, 0, 6'd5, 3'b010, 1'b0, -1);
    add_step(K_LOAD, 1, 1, 6'd5, 3'b001, 1'b0, -1);
    // Cross-port pair, then address and data in separate cycles
    add_step(K_XSTORE, 0, 1, 6'd6, 3'b000, 1'b1, -1);
    add_idle(1, 1);
    add_step(K_LOAD, 1, 1, 6'd6, 3'b000, 1'b1, -1);
    add_step(K_ADDR, 1, 0, 6'd12, 3'b000, 1'b1, -1);
    add_idle(1, -1);
    add_step(K_DATA, 0, 0, '0, 3'b000, 1'b1, -1);
    add_idle(1, 0);
    add_step(K_LOAD, 0, 0, 6'd12, 3'b000, 1'b1, -1);
    // Dual loads
    add_step(K_DUAL, 0, 0, 6'd5, 3'b000, 1'b1, -1);
    add_step(K_DUAL, 0, 1, 6'd5, 3'b000, 1'b1, -1);
    // Queue fills while store-done is stalled
    for (int i = 0; i < 5; i++) begin
      add_step(K_ADDR, 0, 0, ADDR_WIDTH'(20 + i), 3'b100, i < 4, -1);
    end
    for (int i = 0; i < 4; i++) begin
      add_step(K_DATA, 1, 0, '0, 3'b100, 1'b1, -1);
    end
    add_idle(4, 0);
    add_idle(1, -1);
    for (int i = 0; i < 4; i++) begin
      add_step(K_LOAD, i % 2, TAG_WIDTH'(i % 2), ADDR_WIDTH'(20 + i), 3'b000, 1'b1, -1);
    end
    // Address waits alone past the timeout
    add_step(K_RESET, 0, '0, '0, 3'b000, 1'b0, -1);
    add_step(K_ADDR, 0, 1, 6'd30, 3'b000, 1'b1, -1);
    add_idle(17, -1);
    build_err = ERR_STORE_DEADLOCK;
    add_idle(3, -1);
    // Tag out of range wins and stays
    build_err = 16'h0000;
    add_step(K_RESET, 0, '0, '0, 3'b000, 1'b0, -1);
    add_step(K_LOAD, 0, 2, 6'd5, 3'b000, 1'b1, -1);
    build_err = ERR_TAG_OOB;
    add_step(K_ADDR, 0, 0, 6'd31, 3'b000, 1'b1, -1);
    add_idle(20, -1);
  endtask

  // --------------------
  // Drive, check, model

  function automatic logic sends_addr(input int kind);
    return kind == K_ADDR || kind == K_STORE || kind == K_XSTORE;
  endfunction

  function automatic logic sends_data(input int kind);
    return kind == K_DATA || kind == K_STORE || kind == K_XSTORE;
  endfunction

  // Cross-port stores put data on the other port
  function automatic int data_port(input step_t st);
    return (st.kind == K_XSTORE) ? 1 - st.port : st.port;
  endfunction

  task automatic drive_step(input step_t st);
    int dp;
    dp            = data_port(st);
    rst_n         = (st.kind != K_RESET);
    ld_req_valid  = '0;
    ld_req        = '0;
    st_addr_valid = '0;
    st_addr       = '0;
    st_data_valid = '0;
    st_data       = '0;
    ld_resp_ready = st.low[0] ? '0 : '1;
    ld_done_ready = !st.low[1];
    st_done_ready = !st.low[2];
    if (st.kind == K_LOAD || st.kind == K_DUAL) begin
      ld_req_valid[st.port]        = 1'b1;
      ld_req[st.port].as_addr.tag  = st.tag;
      ld_req[st.port].as_addr.addr = st.addr;
    end
    if (st.kind == K_DUAL) begin
      ld_req_valid[1]        = 1'b1;
      ld_req[1].as_addr.tag  = st.tag ^ TAG_WIDTH'(1);
      ld_req[1].as_addr.addr = st.addr + ADDR_WIDTH'(1);
    end
    if (sends_addr(st.kind)) begin
      st_addr_valid[st.port]        = 1'b1;
      st_addr[st.port].as_addr.tag  = st.tag;
      st_addr[st.port].as_addr.addr = st.addr;
    end
    if (sends_data(st.kind)) begin
      st_data_valid[dp]        = 1'b1;
      st_data[dp].as_data.tag  = st.tag;
      st_data[dp].as_data.data = st.data;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_step(input step_t st);
    logic                  exp_v;
    logic                  is_load;
    logic [TAG_WIDTH-1:0]  ptag;
    logic [ADDR_WIDTH-1:0] paddr;
    is_load = (st.kind == K_LOAD || st.kind == K_DUAL);
    check_value("error_valid", error_valid, st.exp_err != 16'h0000);
    check_value("error_code", error_code, st.exp_err);
    if (st.kind == K_RESET) begin
      return;
    end
    for (int p = 0; p < LD_COUNT; p++) begin
      exp_v = (st.kind == K_DUAL) || (st.kind == K_LOAD && st.port == p);
      ptag  = (st.kind == K_DUAL && p == 1) ? st.tag ^ TAG_WIDTH'(1) : st.tag;
      paddr = (st.kind == K_DUAL && p == 1) ? st.addr + ADDR_WIDTH'(1) : st.addr;
      check_value($sformatf("ld_resp_valid[%0d]", p), ld_resp_valid[p], exp_v);
      if (exp_v) begin
        check_value($sformatf("ld_req_ready[%0d]", p), ld_req_ready[p], st.exp_rdy);
        check_value($sformatf("ld_resp[%0d].tag", p), ld_resp[p].as_data.tag, ptag);
        check_value($sformatf("ld_resp[%0d].data", p), ld_resp[p].as_data.data,
                    model_mem[paddr]);
      end
    end
    // ptag now holds the tag of the highest load port
    check_value("ld_done_valid", ld_done_valid, is_load);
    if (is_load) begin
      check_value("ld_done.tag", ld_done.as_data.tag, ptag);
      check_value("ld_done.data", ld_done.as_data.data, '0);
    end
    if (sends_addr(st.kind)) begin
      check_value($sformatf("st_addr_ready[%0d]", st.port), st_addr_ready[st.port],
                  st.exp_rdy);
    end
    if (sends_data(st.kind)) begin
      check_value($sformatf("st_data_ready[%0d]", data_port(st)),
                  st_data_ready[data_port(st)], st.exp_rdy);
    end
    check_value("st_done_valid", st_done_valid, st.exp_st_done >= 0);
    if (st.exp_st_done >= 0) begin
      check_value("st_done.tag", st_done.as_data.tag, st.exp_st_done);
      check_value("st_done.data", st_done.as_data.data, '0);
    end
  endtask

  task automatic update_model(input step_t st);
    int                    t;
    logic [ADDR_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] d;
    if (st.kind == K_RESET) begin
      for (int i = 0; i < ST_COUNT; i++) begin
        addr_q[i].delete();
        data_q[i].delete();
      end
      return;
    end
    if (st.exp_st_done >= 0) begin
      t = st.exp_st_done;
      if (addr_q[t].size() == 0 || data_q[t].size() == 0) begin
        other_count++;
        $display("Error at %0t: store-done expected for tag %0d with nothing queued",
                 $time, t);
      end else begin
        a = addr_q[t].pop_front();
        d = data_q[t].pop_front();
        model_mem[a] = d;
      end
    end
    // Out-of-range store tags land in queue 0
    t = (int'(st.tag) >= ST_COUNT) ? 0 : int'(st.tag);
    if (st.exp_rdy && sends_addr(st.kind)) begin
      addr_q[t].push_back(st.addr);
    end
    if (st.exp_rdy && sends_data(st.kind)) begin
      data_q[t].push_back(st.data);
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_count, other_count, dut0.u_chk.fail_count);
  endtask

  // --------------------
  // Run limit

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > 3 * n_steps + 200) begin
      $display("Timeout: run did not finish within %0d cycles", 3 * n_steps + 200);
      report_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int total;
    void'($urandom(32'hcb9f_4529));
    rst_n         = 1'b0;
    ld_req_valid  = '0;
    ld_req        = '0;
    ld_resp_ready = '1;
    ld_done_ready = 1'b1;
    st_addr_valid = '0;
    st_addr       = '0;
    st_data_valid = '0;
    st_data       = '0;
    st_done_ready = 1'b1;
    build_table();
    repeat (8) @(posedge clk);

    for (int s = 0; s < n_steps; s++) begin
      #1;
      drive_step(steps[s]);
      #2;
      check_step(steps[s]);
      update_model(steps[s]);
      @(posedge clk);
    end

    total = mismatch_count + other_count + dut0.u_chk.fail_count;
    report_counts();
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== scratchpad_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module scratchpad_checker (
  input wire logic                                clk,
  input wire logic                                rst_n,
  input wire logic [scratchpad_pkg::LD_COUNT-1:0] ld_req_valid,
  input wire logic [scratchpad_pkg::LD_COUNT-1:0] ld_resp_valid,
  input wire logic                                st_done_valid,
  input wire scratchpad_pkg::payload_u            st_done,
  input wire logic                                error_valid
);

  import scratchpad_pkg::*;

  int fail_count = 0;

  // Sticky error only clears through reset
  a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    error_valid |=> error_valid)
    else begin
      fail_count++;
      $error("error_valid fell without a reset");
    end

  a_st_done_tag: assert property (@(posedge clk) disable iff (!rst_n)
    st_done_valid |-> (int'(st_done.as_data.tag) < ST_COUNT))
    else begin
      fail_count++;
      $error("st_done tag out of range");
    end

  // Zero-latency loads
  a_resp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    ld_resp_valid == ld_req_valid)
    else begin
      fail_count++;
      $error("ld_resp_valid differs from ld_req_valid");
    end

endmodule

bind scratchpad_memory scratchpad_checker u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .ld_req_valid  (ld_req_valid),
  .ld_resp_valid (ld_resp_valid),
  .st_done_valid (st_done_valid),
  .st_done       (st_done),
  .error_valid   (error_valid)
);

`default_nettype wire

// ==== scratchpad_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module scratchpad_memory #(
  parameter int LSQ_DEPTH        = 4,
  parameter int DEADLOCK_TIMEOUT = 16
) (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  // Load requests and responses
  input  logic [scratchpad_pkg::LD_COUNT-1:0]                     ld_req_valid,
  output logic [scratchpad_pkg::LD_COUNT-1:0]                     ld_req_ready,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::LD_COUNT-1:0] ld_req,
  output logic [scratchpad_pkg::LD_COUNT-1:0]                     ld_resp_valid,
  input  logic [scratchpad_pkg::LD_COUNT-1:0]                     ld_resp_ready,
  output scratchpad_pkg::payload_u [scratchpad_pkg::LD_COUNT-1:0] ld_resp,
  output logic                                                    ld_done_valid,
  input  logic                                                    ld_done_ready,
  output scratchpad_pkg::payload_u                                ld_done,
  // Store address and data requests
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                     st_addr_valid,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                     st_addr_ready,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::ST_COUNT-1:0] st_addr,
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                     st_data_valid,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                     st_data_ready,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::ST_COUNT-1:0] st_data,
  output logic                                                    st_done_valid,
  input  logic                                                    st_done_ready,
  output scratchpad_pkg::payload_u                                st_done,
  // Sticky error
  output logic                                                    error_valid,
  output logic [15:0]                                             error_code
);

  import scratchpad_pkg::*;

  logic [LD_COUNT-1:0][ADDR_WIDTH-1:0] rd_addr;
  logic [LD_COUNT-1:0][DATA_WIDTH-1:0] rd_data;
  logic [ST_COUNT-1:0]                 wr_en;
  logic [ST_COUNT-1:0][ADDR_WIDTH-1:0] wr_addr;
  logic [ST_COUNT-1:0][DATA_WIDTH-1:0] wr_data;
  logic                                ld_tag_oob;
  logic                                st_tag_oob;
  logic [ST_COUNT-1:0]                 deadlock;

  mem_array u_mem (
    .clk     (clk),
    .rd_addr (rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  load_ports u_load (
    .ld_req_valid  (ld_req_valid),
    .ld_req        (ld_req),
    .ld_resp_ready (ld_resp_ready),
    .ld_done_ready (ld_done_ready),
    .rd_data       (rd_data),
    .ld_req_ready  (ld_req_ready),
    .ld_resp_valid (ld_resp_valid),
    .ld_resp       (ld_resp),
    .ld_done_valid (ld_done_valid),
    .ld_done       (ld_done),
    .rd_addr       (rd_addr),
    .tag_oob       (ld_tag_oob)
  );

  store_unit #(
    .LSQ_DEPTH        (LSQ_DEPTH),
    .DEADLOCK_TIMEOUT (DEADLOCK_TIMEOUT)
  ) u_store (
    .clk           (clk),
    .rst_n         (rst_n),
    .st_addr_valid (st_addr_valid),
    .st_addr       (st_addr),
    .st_data_valid (st_data_valid),
    .st_data       (st_data),
    .st_done_ready (st_done_ready),
    .st_addr_ready (st_addr_ready),
    .st_data_ready (st_data_ready),
    .st_done_valid (st_done_valid),
    .st_done       (st_done),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .tag_oob       (st_tag_oob),
    .deadlock      (deadlock)
  );

  error_reporter u_err (
    .clk         (clk),
    .rst_n       (rst_n),
    .ld_tag_oob  (ld_tag_oob),
    .st_tag_oob  (st_tag_oob),
    .deadlock    (deadlock),
    .error_valid (error_valid),
    .error_code  (error_code)
  );

endmodule

`default_nettype wire

// ==== error_reporter.sv ====
`timescale 1ns/100ps
`default_nettype none

module error_reporter (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                ld_tag_oob,
  input  logic                                st_tag_oob,
  input  logic [scratchpad_pkg::ST_COUNT-1:0] deadlock,
  output logic                                error_valid,
  output logic [15:0]                         error_code
);

  import scratchpad_pkg::*;

  logic        err_detect;
  logic [15:0] err_code_next;

  // Tag range errors outrank deadlock
  assign err_detect    = ld_tag_oob || st_tag_oob || (|deadlock);
  assign err_code_next = (ld_tag_oob || st_tag_oob) ? ERR_TAG_OOB : ERR_STORE_DEADLOCK;

  // First error sticks until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_valid <= 1'b0;
      error_code  <= 16'd0;
    end else if (!error_valid && err_detect) begin
      error_valid <= 1'b1;
      error_code  <= err_code_next;
    end
  end

endmodule

`default_nettype wire

// ==== store_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_unit #(
  parameter int LSQ_DEPTH        = 4,
  parameter int DEADLOCK_TIMEOUT = 16
) (
  input  logic                                                                 clk,
  input  logic                                                                 rst_n,
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_addr_valid,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::ST_COUNT-1:0]              st_addr,
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_data_valid,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::ST_COUNT-1:0]              st_data,
  input  logic                                                                 st_done_ready,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_addr_ready,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_data_ready,
  output logic                                                                 st_done_valid,
  output scratchpad_pkg::payload_u                                             st_done,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  wr_en,
  output logic [scratchpad_pkg::ST_COUNT-1:0][scratchpad_pkg::ADDR_WIDTH-1:0] wr_addr,
  output logic [scratchpad_pkg::ST_COUNT-1:0][scratchpad_pkg::DATA_WIDTH-1:0] wr_data,
  output logic                                                                 tag_oob,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  deadlock
);

  import scratchpad_pkg::*;

  logic [ST_COUNT-1:0]                 addr_full;
  logic [ST_COUNT-1:0]                 data_full;
  logic [ST_COUNT-1:0]                 addr_push;
  logic [ST_COUNT-1:0][ADDR_WIDTH-1:0] addr_push_val;
  logic [ST_COUNT-1:0]                 data_push;
  logic [ST_COUNT-1:0][DATA_WIDTH-1:0] data_push_val;

  store_tag_router u_router (
    .st_addr_valid (st_addr_valid),
    .st_addr       (st_addr),
    .st_data_valid (st_data_valid),
    .st_data       (st_data),
    .addr_full     (addr_full),
    .data_full     (data_full),
    .st_addr_ready (st_addr_ready),
    .st_data_ready (st_data_ready),
    .addr_push     (addr_push),
    .addr_push_val (addr_push_val),
    .data_push     (data_push),
    .data_push_val (data_push_val),
    .tag_oob       (tag_oob)
  );

  // --------------------
  // One pair queue per store tag
  for (genvar t = 0; t < ST_COUNT; t++) begin : g_tag
    store_pair_queue #(
      .LSQ_DEPTH        (LSQ_DEPTH),
      .DEADLOCK_TIMEOUT (DEADLOCK_TIMEOUT)
    ) u_queue (
      .clk           (clk),
      .rst_n         (rst_n),
      .addr_push     (addr_push[t]),
      .addr_push_val (addr_push_val[t]),
      .data_push     (data_push[t]),
      .data_push_val (data_push_val[t]),
      .st_done_ready (st_done_ready),
      .addr_full     (addr_full[t]),
      .data_full     (data_full[t]),
      .pair          (wr_en[t]),
      .pair_addr     (wr_addr[t]),
      .pair_data     (wr_data[t]),
      .deadlock      (deadlock[t])
    );
  end

  // Store-done reports the highest pairing tag
  always_comb begin
    st_done       = '0;
    st_done_valid = |wr_en;
    for (int t = 0; t < ST_COUNT; t++) begin
      if (wr_en[t]) begin
        st_done.as_data.tag = TAG_WIDTH'(t);
      end
    end
  end

endmodule

`default_nettype wire

// ==== store_pair_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_pair_queue #(
  parameter int LSQ_DEPTH        = 4,
  parameter int DEADLOCK_TIMEOUT = 16
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  addr_push,
  input  logic [scratchpad_pkg::ADDR_WIDTH-1:0] addr_push_val,
  input  logic                                  data_push,
  input  logic [scratchpad_pkg::DATA_WIDTH-1:0] data_push_val,
  input  logic                                  st_done_ready,
  output logic                                  addr_full,
  output logic                                  data_full,
  output logic                                  pair,
  output logic [scratchpad_pkg::ADDR_WIDTH-1:0] pair_addr,
  output logic [scratchpad_pkg::DATA_WIDTH-1:0] pair_data,
  output logic                                  deadlock
);

  import scratchpad_pkg::*;

  localparam int PTR_W = $clog2(LSQ_DEPTH > 1 ? LSQ_DEPTH : 2);
  localparam int CNT_W = $clog2(LSQ_DEPTH + 1);
  localparam int DL_W  = $clog2(DEADLOCK_TIMEOUT + 1);

  // Queue 0 holds addresses and queue 1 holds data
  logic [1:0]                 q_push;
  logic [1:0]                 q_full;
  logic [1:0]                 q_empty;
  logic [1:0][DATA_WIDTH-1:0] q_in;
  logic [1:0][DATA_WIDTH-1:0] q_head;
  logic                       waiting;
  logic [DL_W-1:0]            dl_count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(LSQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign q_push = {data_push, addr_push};
  assign q_in[0] = DATA_WIDTH'(addr_push_val);
  assign q_in[1] = data_push_val;

  // --------------------
  // Circular queues where push and pop may share a cycle
  for (genvar q = 0; q < 2; q++) begin : g_queue
    logic [DATA_WIDTH-1:0] slots [LSQ_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (q_push[q]) begin
          wr_ptr <= next_ptr(wr_ptr);
        end
        if (pair) begin
          rd_ptr <= next_ptr(rd_ptr);
        end
        if (q_push[q] && !pair) begin
          count <= count + 1'b1;
        end else if (!q_push[q] && pair) begin
          count <= count - 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (q_push[q]) begin
        slots[wr_ptr] <= q_in[q];
      end
    end

    assign q_head[q]  = slots[rd_ptr];
    assign q_full[q]  = (count == CNT_W'(LSQ_DEPTH));
    assign q_empty[q] = (count == '0);
  end

  assign addr_full = q_full[0];
  assign data_full = q_full[1];

  // Both heads present and done port free
  assign pair      = !q_empty[0] && !q_empty[1] && st_done_ready;
  assign pair_addr = q_head[0][ADDR_WIDTH-1:0];
  assign pair_data = q_head[1];

  // --------------------
  // One-sided wait counter that saturates at the timeout
  assign waiting = q_empty[0] ^ q_empty[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dl_count <= '0;
    end else if (!waiting) begin
      dl_count <= '0;
    end else if (dl_count != DL_W'(DEADLOCK_TIMEOUT)) begin
      dl_count <= dl_count + 1'b1;
    end
  end

  assign deadlock = (dl_count == DL_W'(DEADLOCK_TIMEOUT));

endmodule

`default_nettype wire

// ==== store_tag_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_tag_router (
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_addr_valid,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::ST_COUNT-1:0]              st_addr,
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_data_valid,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::ST_COUNT-1:0]              st_data,
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                                  addr_full,
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                                  data_full,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_addr_ready,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  st_data_ready,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  addr_push,
  output logic [scratchpad_pkg::ST_COUNT-1:0][scratchpad_pkg::ADDR_WIDTH-1:0] addr_push_val,
  output logic [scratchpad_pkg::ST_COUNT-1:0]                                  data_push,
  output logic [scratchpad_pkg::ST_COUNT-1:0][scratchpad_pkg::DATA_WIDTH-1:0] data_push_val,
  output logic                                                                 tag_oob
);

  import scratchpad_pkg::*;

  // Out-of-range tags fall back to queue 0
  function automatic int target_tag(input logic [TAG_WIDTH-1:0] tag);
    return (int'(tag) >= ST_COUNT) ? 0 : int'(tag);
  endfunction

  always_comb begin
    int tgt;
    addr_push     = '0;
    addr_push_val = '0;
    data_push     = '0;
    data_push_val = '0;
    tag_oob       = 1'b0;

    // --------------------
    // Address requests
    for (int p = 0; p < ST_COUNT; p++) begin
      tgt = target_tag(st_addr[p].as_addr.tag);
      st_addr_ready[p] = !addr_full[tgt];
      if (st_addr_valid[p]) begin
        if (int'(st_addr[p].as_addr.tag) >= ST_COUNT) begin
          tag_oob = 1'b1;
        end
        if (!addr_full[tgt]) begin
          addr_push[tgt]     = 1'b1;
          addr_push_val[tgt] = st_addr[p].as_addr.addr;
        end
      end
    end

    // --------------------
    // Data requests
    for (int p = 0; p < ST_COUNT; p++) begin
      tgt = target_tag(st_data[p].as_data.tag);
      st_data_ready[p] = !data_full[tgt];
      if (st_data_valid[p]) begin
        if (int'(st_data[p].as_data.tag) >= ST_COUNT) begin
          tag_oob = 1'b1;
        end
        if (!data_full[tgt]) begin
          data_push[tgt]     = 1'b1;
          data_push_val[tgt] = st_data[p].as_data.data;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== load_ports.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_ports (
  input  logic [scratchpad_pkg::LD_COUNT-1:0]                                  ld_req_valid,
  input  scratchpad_pkg::payload_u [scratchpad_pkg::LD_COUNT-1:0]              ld_req,
  input  logic [scratchpad_pkg::LD_COUNT-1:0]                                  ld_resp_ready,
  input  logic                                                                 ld_done_ready,
  input  logic [scratchpad_pkg::LD_COUNT-1:0][scratchpad_pkg::DATA_WIDTH-1:0] rd_data,
  output logic [scratchpad_pkg::LD_COUNT-1:0]                                  ld_req_ready,
  output logic [scratchpad_pkg::LD_COUNT-1:0]                                  ld_resp_valid,
  output scratchpad_pkg::payload_u [scratchpad_pkg::LD_COUNT-1:0]              ld_resp,
  output logic                                                                 ld_done_valid,
  output scratchpad_pkg::payload_u                                             ld_done,
  output logic [scratchpad_pkg::LD_COUNT-1:0][scratchpad_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic                                                                 tag_oob
);

  import scratchpad_pkg::*;

  always_comb begin
    ld_resp       = '0;
    ld_done       = '0;
    ld_done_valid = 1'b0;
    tag_oob       = 1'b0;
    for (int i = 0; i < LD_COUNT; i++) begin
      rd_addr[i]       = ld_req[i].as_addr.addr;
      ld_resp_valid[i] = ld_req_valid[i];
      // A load only completes if both its response and the done port can take it
      ld_req_ready[i]  = ld_req_valid[i] && ld_resp_ready[i] && ld_done_ready;

      // Response reuses the request tag with a zero-cycle read
      ld_resp[i].as_data.tag  = ld_req[i].as_addr.tag;
      ld_resp[i].as_data.data = rd_data[i];

      // Highest valid port overrides the done tag
      if (ld_req_valid[i]) begin
        ld_done_valid          = 1'b1;
        ld_done.as_data.tag    = ld_req[i].as_addr.tag;
        if (int'(ld_req[i].as_addr.tag) >= LD_COUNT) begin
          tag_oob = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== mem_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_array (
  input  logic                                                                 clk,
  input  logic [scratchpad_pkg::LD_COUNT-1:0][scratchpad_pkg::ADDR_WIDTH-1:0] rd_addr,
  input  logic [scratchpad_pkg::ST_COUNT-1:0]                                  wr_en,
  input  logic [scratchpad_pkg::ST_COUNT-1:0][scratchpad_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic [scratchpad_pkg::ST_COUNT-1:0][scratchpad_pkg::DATA_WIDTH-1:0] wr_data,
  output logic [scratchpad_pkg::LD_COUNT-1:0][scratchpad_pkg::DATA_WIDTH-1:0] rd_data
);

  import scratchpad_pkg::*;

  logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

  // Later ports overwrite earlier ones on an address clash
  always_ff @(posedge clk) begin
    for (int i = 0; i < ST_COUNT; i++) begin
      if (wr_en[i]) begin
        mem[wr_addr[i]] <= wr_data[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LD_COUNT; i++) begin
      rd_data[i] = mem[rd_addr[i]];
    end
  end

endmodule

`default_nettype wire

// ==== scratchpad_pkg.sv ====
`default_nettype none

package scratchpad_pkg;

  // Word and tag geometry
  localparam int DATA_WIDTH    = 32;
  localparam int TAG_WIDTH     = 2;
  localparam int PAYLOAD_WIDTH = TAG_WIDTH + DATA_WIDTH;
  localparam int MEM_DEPTH     = 64;
  localparam int ADDR_WIDTH    = $clog2(MEM_DEPTH);

  // Store tags map one to one onto store ports
  localparam int LD_COUNT = 2;
  localparam int ST_COUNT = 2;

  localparam logic [15:0] ERR_TAG_OOB        = 16'h0301;
  localparam logic [15:0] ERR_STORE_DEADLOCK = 16'h0302;

  // Address view for load requests and store addresses
  typedef struct packed {
    logic [TAG_WIDTH-1:0]             tag;
    logic [DATA_WIDTH-ADDR_WIDTH-1:0] pad;
    logic [ADDR_WIDTH-1:0]            addr;
  } addr_word_t;

  // Data view for store data, load responses and done strobes
  typedef struct packed {
    logic [TAG_WIDTH-1:0]  tag;
    logic [DATA_WIDTH-1:0] data;
  } data_word_t;

  typedef union packed {
    addr_word_t as_addr;
    data_word_t as_data;
  } payload_u;

endpackage

`default_nettype wire
